/* sim.f */
+incdir+bench
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_queue.sv
design/load_align.sv
design/lsu_top.sv
bench/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - design/lsu_pkg.sv
      - design/lsu_agu.sv
      - design/lsu_queue.sv
      - design/load_align.sv
      - design/lsu_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/lsu_tb.sv

/* bench/lsu_ref.svh */
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

// Reference memory of 256 words, advanced in program order by the checker
logic [31:0] ref_mem [256];

// Start value of a word, every address bit matters
function automatic logic [31:0] fill_word(input int unsigned idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a ^ 8'h5a, ~a, a * 8'd3, a + 8'h91};
endfunction

// Byte lanes covered by the access size, starting at the addressed byte
function automatic logic [3:0] access_mask(input lsu_pkg::lsu_op_e op,
                                           input logic [31:0] addr);
    int nbytes;
    case (op)
        lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU, lsu_pkg::MEM_SB: nbytes = 1;
        lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: nbytes = 2;
        default: nbytes = 4;
    endcase
    return 4'(((1 << nbytes) - 1) << addr[1:0]);
endfunction

// Store data placed on the byte lanes it writes
function automatic logic [31:0] store_lanes(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                                            input logic [31:0] rs2);
    case (op)
        lsu_pkg::MEM_SB: return {24'h0, rs2[7:0]} << (8 * addr[1:0]);
        lsu_pkg::MEM_SH: return {16'h0, rs2[15:0]} << (8 * addr[1:0]);
        default:         return rs2;
    endcase
endfunction

function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                           input logic [3:0] wmask);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
        if (wmask[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
endfunction

function automatic logic [31:0] load_result(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                                            input logic [31:0] word);
    logic [31:0] sh;
    sh = word >> (8 * addr[1:0]);
    case (op)
        lsu_pkg::MEM_LB:  return {{24{sh[7]}}, sh[7:0]};
        lsu_pkg::MEM_LBU: return {24'h0, sh[7:0]};
        lsu_pkg::MEM_LH:  return {{16{sh[15]}}, sh[15:0]};
        lsu_pkg::MEM_LHU: return {16'h0, sh[15:0]};
        default:          return word;
    endcase
endfunction

`endif

/* bench/lsu_tb.sv */
`default_nettype none

module lsu_tb;

    import lsu_pkg::*;

    `include "lsu_ref.svh"

    localparam int MAX_OPS  = 320;
    localparam int N_RANDOM = 200;
    localparam int MEM_WORDS = 256;

    logic       clk;
    logic       rst;
    logic       disp_valid;
    logic       disp_ready;
    lsu_uop_t   disp_uop;
    logic       agu_valid;
    lsu_op_e    agu_op;
    agu_req_t   agu_req;
    logic [ROB_IDX-1:0] rob_head;
    dmem_req_t  dmem_req;
    logic       dmem_resp;
    logic [XLEN-1:0] dmem_rdata;
    logic       cdb_valid;
    cdb_t       cdb;

    // Program in dispatch order
    lsu_op_e     ops     [MAX_OPS];
    logic [31:0] op_addr [MAX_OPS];
    logic [31:0] op_rs2  [MAX_OPS];
    string       op_name [MAX_OPS];
    int          n_ops;
    int          ret_count;
    int          cycle_count;
    int          timeout_limit;
    int          head_wait;
    bit          failed;

    // Memory model state
    logic [31:0] mem_model [MEM_WORDS];
    logic        busy;
    int          wait_cnt;
    dmem_req_t   held_req;

    lsu_top #(
        .LSQ_DEPTH (8)
    ) u_lsu_top (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_uop   (disp_uop),
        .agu_valid  (agu_valid),
        .agu_op     (agu_op),
        .agu_req    (agu_req),
        .rob_head   (rob_head),
        .dmem_req   (dmem_req),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [ROB_IDX-1:0] rob_of(input int i);
        return ROB_IDX'(i % 32);
    endfunction

    function automatic logic [PHY_IDX-1:0] phy_of(input int i);
        return PHY_IDX'((i * 7 + 3) % 64);
    endfunction

    task automatic stop_with_error(input string msg);
        failed = 1'b1;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic add_op(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] rs2,
                          input string name);
        ops[n_ops]     = op;
        op_addr[n_ops] = addr;
        op_rs2[n_ops]  = rs2;
        op_name[n_ops] = name;
        n_ops++;
    endtask

    task automatic build_program();
        lsu_op_e kinds [8];
        lsu_op_e k;
        logic [5:0] word;
        logic [1:0] lane;
        kinds = '{MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW};
        for (int off = 0; off < 4; off++) begin
            add_op(MEM_LB, 32'h40 + off, 0, "load_lb");
            add_op(MEM_LBU, 32'h40 + off, 0, "load_lbu");
        end
        for (int off = 0; off < 4; off += 2) begin
            add_op(MEM_LH, 32'h84 + off, 0, "load_lh");
            add_op(MEM_LHU, 32'h84 + off, 0, "load_lhu");
        end
        add_op(MEM_LW, 32'hc8, 0, "load_lw");
        // Stores, each read back right after
        add_op(MEM_SB, 32'h101, 32'h0000_00a7, "store_sb");
        add_op(MEM_LW, 32'h100, 0, "store_readback");
        add_op(MEM_SH, 32'h102, 32'h0000_8e31, "store_sh");
        add_op(MEM_LW, 32'h100, 0, "store_readback");
        add_op(MEM_SW, 32'h104, 32'hdead_beef, "store_sw");
        add_op(MEM_LB, 32'h107, 0, "store_readback");
        for (int i = 0; i < N_RANDOM; i++) begin
            k    = kinds[$urandom_range(0, 7)];
            word = 6'($urandom_range(0, 63));
            lane = 2'($urandom);
            // Natural alignment for halfwords and words
            if (access_mask(k, 0) == 4'hf) begin
                lane = 2'b00;
            end else if (access_mask(k, 0) == 4'h3) begin
                lane[0] = 1'b0;
            end
            add_op(k, {24'h0, word, lane}, $urandom, "random_mix");
        end
    endtask

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            dmem_resp <= 1'b0;
            busy      <= 1'b0;
        end else if (dmem_resp) begin
            dmem_resp <= 1'b0;
        end else if (busy) begin
            assert (dmem_req == held_req)
                else stop_with_error("Memory request changed before the response");
            if (wait_cnt == 0) begin
                dmem_resp  <= 1'b1;
                dmem_rdata <= mem_model[held_req.addr[9:2]];
                mem_model[held_req.addr[9:2]] = merge_word(mem_model[held_req.addr[9:2]],
                                                           held_req.wdata, held_req.wmask);
                busy <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if ((dmem_req.rmask | dmem_req.wmask) != 4'h0) begin
            // New access, checked against the oldest unretired op
            assert (dmem_req.addr == {op_addr[ret_count][31:2], 2'b00})
                else stop_with_error($sformatf("Mismatch %s addr: expected %h, actual %h",
                    op_name[ret_count], {op_addr[ret_count][31:2], 2'b00}, dmem_req.addr));
            if (ops[ret_count][3]) begin
                assert (dmem_req.wmask == access_mask(ops[ret_count], op_addr[ret_count])
                        && dmem_req.rmask == 4'h0)
                    else stop_with_error($sformatf("Mismatch %s wmask: expected %h, actual %h",
                        op_name[ret_count], access_mask(ops[ret_count], op_addr[ret_count]),
                        dmem_req.wmask));
                assert (dmem_req.wdata ==
                        store_lanes(ops[ret_count], op_addr[ret_count], op_rs2[ret_count]))
                    else stop_with_error($sformatf("Mismatch %s wdata: expected %h, actual %h",
                        op_name[ret_count],
                        store_lanes(ops[ret_count], op_addr[ret_count], op_rs2[ret_count]),
                        dmem_req.wdata));
            end else begin
                assert (dmem_req.rmask == access_mask(ops[ret_count], op_addr[ret_count])
                        && dmem_req.wmask == 4'h0)
                    else stop_with_error($sformatf("Mismatch %s rmask: expected %h, actual %h",
                        op_name[ret_count], access_mask(ops[ret_count], op_addr[ret_count]),
                        dmem_req.rmask));
            end
            busy     <= 1'b1;
            held_req <= dmem_req;
            wait_cnt <= $urandom_range(0, 2);
        end
    end

    ////////////////////////////////////////
    // CDB checker
    ////////////////////////////////////////

    always @(posedge clk) begin
        logic [31:0] exp_value;
        if (!rst) begin
            if (dmem_req.wmask != 4'h0) begin
                assert (rob_head == rob_of(ret_count))
                    else stop_with_error("Store issued before reaching the ROB head");
            end
            assert (cdb_valid == dmem_resp)
                else stop_with_error("CDB beat not in the cycle of the memory response");
            if (cdb_valid) begin
                assert (ret_count < n_ops)
                    else stop_with_error("CDB result with no op left in the program");
                exp_value = ops[ret_count][3] ? 32'h0
                    : load_result(ops[ret_count], op_addr[ret_count],
                                  ref_mem[op_addr[ret_count][9:2]]);
                assert (cdb.rob_id == rob_of(ret_count) && cdb.rd_phy == phy_of(ret_count))
                    else stop_with_error($sformatf("Mismatch %s tag: expected %h/%h, actual %h/%h",
                        op_name[ret_count], rob_of(ret_count), phy_of(ret_count),
                        cdb.rob_id, cdb.rd_phy));
                assert (cdb.value == exp_value)
                    else stop_with_error($sformatf("Mismatch %s value: expected %h, actual %h",
                        op_name[ret_count], exp_value, cdb.value));
                if (ops[ret_count][3]) begin
                    ref_mem[op_addr[ret_count][9:2]] = merge_word(
                        ref_mem[op_addr[ret_count][9:2]],
                        store_lanes(ops[ret_count], op_addr[ret_count], op_rs2[ret_count]),
                        access_mask(ops[ret_count], op_addr[ret_count]));
                end
                ret_count <= ret_count + 1;
            end
        end
    end

    // ROB head catches up a few cycles after each retirement
    always @(posedge clk) begin
        if (!rst) begin
            if (cdb_valid) begin
                head_wait <= $urandom_range(0, 2);
            end else if (rob_head != rob_of(ret_count)) begin
                if (head_wait == 0) begin
                    rob_head <= rob_of(ret_count);
                end else begin
                    head_wait <= head_wait - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            stop_with_error("Timeout, the LSU stopped producing results");
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic dispatch_op(input int i);
        disp_valid      <= 1'b1;
        disp_uop.rob_id <= rob_of(i);
        disp_uop.rd_phy <= phy_of(i);
        disp_uop.op     <= ops[i];
        @(posedge clk);
        while (!disp_ready) @(posedge clk);
    endtask

    task automatic send_agu(input int i);
        logic [11:0] imm;
        imm = 12'($urandom);
        agu_valid      <= 1'b1;
        agu_op         <= ops[i];
        agu_req.rob_id <= rob_of(i);
        agu_req.imm    <= imm;
        agu_req.rs1    <= op_addr[i] - {{20{imm[11]}}, imm};
        agu_req.rs2    <= op_rs2[i];
        @(posedge clk);
    endtask

    initial begin
        int order [8];
        int pos;
        int cnt;
        int j;
        int t;
        void'($urandom(32'hca2040b9));
        n_ops       = 0;
        ret_count   = 0;
        cycle_count = 0;
        head_wait   = 0;
        failed      = 1'b0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_model[w] = fill_word(w);
            ref_mem[w]   = fill_word(w);
        end
        build_program();
        timeout_limit = 16 + 40 * n_ops;

        rst        <= 1'b1;
        disp_valid <= 1'b0;
        disp_uop   <= '0;
        agu_valid  <= 1'b0;
        agu_op     <= MEM_LW;
        agu_req    <= '0;
        rob_head   <= '0;
        dmem_resp  <= 1'b0;
        dmem_rdata <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        assert (disp_ready && !cdb_valid && dmem_req.rmask == 0 && dmem_req.wmask == 0)
            else stop_with_error("Outputs not idle after reset");

        @(posedge clk);
        pos = 0;
        while (pos < n_ops) begin
            cnt = (n_ops - pos < 8) ? n_ops - pos : 8;
            for (int i = 0; i < cnt; i++) begin
                dispatch_op(pos + i);
            end
            disp_valid <= 1'b0;
            if (cnt == 8) begin
                @(negedge clk);
                assert (!disp_ready)
                    else stop_with_error("disp_ready high with eight ops in the queue");
                @(posedge clk);
            end
            // Addresses arrive in shuffled order
            for (int i = 0; i < cnt; i++) order[i] = pos + i;
            for (int i = cnt - 1; i > 0; i--) begin
                j = $urandom_range(0, i);
                t = order[i];
                order[i] = order[j];
                order[j] = t;
            end
            for (int i = 0; i < cnt; i++) begin
                send_agu(order[i]);
            end
            agu_valid <= 1'b0;
            while (ret_count < pos + cnt) @(posedge clk);
            pos += cnt;
        end

        repeat (4) @(posedge clk);
        if (!failed && ret_count == n_ops) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`default_nettype none

module lsu_top #(
    parameter int unsigned LSQ_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        disp_valid,
    output logic                        disp_ready,
    input  lsu_pkg::lsu_uop_t           disp_uop,

    input  logic                        agu_valid,
    input  lsu_pkg::lsu_op_e            agu_op,
    input  lsu_pkg::agu_req_t           agu_req,

    input  logic [lsu_pkg::ROB_IDX-1:0] rob_head,

    output lsu_pkg::dmem_req_t          dmem_req,
    input  logic                        dmem_resp,
    input  logic [lsu_pkg::XLEN-1:0]    dmem_rdata,

    output logic                        cdb_valid,
    output lsu_pkg::cdb_t               cdb
);

    import lsu_pkg::*;

    logic            agu_res_valid;
    agu_res_t        agu_res;
    lsu_op_e         head_op;
    logic [1:0]      head_offset;
    logic [XLEN-1:0] load_value;

    lsu_agu u_lsu_agu (
        .clk           (clk),
        .rst           (rst),
        .agu_valid     (agu_valid),
        .agu_req       (agu_req),
        .agu_op        (agu_op),
        .agu_res_valid (agu_res_valid),
        .agu_res       (agu_res)
    );

    lsu_queue #(
        .LSQ_DEPTH (LSQ_DEPTH)
    ) u_lsu_queue (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_ready    (disp_ready),
        .disp_uop      (disp_uop),
        .agu_res_valid (agu_res_valid),
        .agu_res       (agu_res),
        .rob_head      (rob_head),
        .dmem_req      (dmem_req),
        .dmem_resp     (dmem_resp),
        .head_op       (head_op),
        .head_offset   (head_offset),
        .load_value    (load_value),
        .cdb_valid     (cdb_valid),
        .cdb           (cdb)
    );

    // Memory word to register value
    load_align u_load_align (
        .op     (head_op),
        .offset (head_offset),
        .rdata  (dmem_rdata),
        .value  (load_value)
    );

endmodule

`default_nettype wire

/* design/load_align.sv */
`default_nettype none

module load_align (
    input  lsu_pkg::lsu_op_e         op,
    input  logic [1:0]               offset,
    input  logic [lsu_pkg::XLEN-1:0] rdata,
    output logic [lsu_pkg::XLEN-1:0] value
);

    import lsu_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Lane picked by the low address bits
    always_comb begin
        case (offset)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (op)
            MEM_LB:  value = {{(XLEN-8){byte_sel[7]}}, byte_sel};
            MEM_LBU: value = {{(XLEN-8){1'b0}}, byte_sel};
            MEM_LH:  value = {{(XLEN-16){half_sel[15]}}, half_sel};
            MEM_LHU: value = {{(XLEN-16){1'b0}}, half_sel};
            // Full word for LW
            default: value = rdata;
        endcase
    end

endmodule

`default_nettype wire

/* design/lsu_queue.sv */
`default_nettype none

module lsu_queue #(
    parameter int unsigned LSQ_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       disp_valid,
    output logic                       disp_ready,
    input  lsu_pkg::lsu_uop_t          disp_uop,

    input  logic                       agu_res_valid,
    input  lsu_pkg::agu_res_t          agu_res,

    input  logic [lsu_pkg::ROB_IDX-1:0] rob_head,

    output lsu_pkg::dmem_req_t         dmem_req,
    input  logic                       dmem_resp,

    output lsu_pkg::lsu_op_e           head_op,
    output logic [1:0]                 head_offset,
    input  logic [lsu_pkg::XLEN-1:0]   load_value,

    output logic                       cdb_valid,
    output lsu_pkg::cdb_t              cdb
);

    import lsu_pkg::*;

    localparam int LSQ_IDX = $clog2(LSQ_DEPTH);

    lsq_entry_t           entries [LSQ_DEPTH];
    logic [LSQ_DEPTH-1:0] occupied;
    logic [LSQ_DEPTH-1:0] agu_hit;

    logic [LSQ_IDX:0]     wr_ptr;
    logic [LSQ_IDX:0]     rd_ptr;
    logic [LSQ_IDX-1:0]   wr_idx;
    logic [LSQ_IDX-1:0]   rd_idx;

    logic                 full;
    logic                 empty;
    logic                 enqueue;
    logic                 dequeue;

    lsq_entry_t           head;
    logic                 head_store;
    logic                 issue;

    ////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////

    assign wr_idx = wr_ptr[LSQ_IDX-1:0];
    assign rd_idx = rd_ptr[LSQ_IDX-1:0];

    // Same slot, wrap flags differ
    assign full  = (wr_idx == rd_idx) && (wr_ptr[LSQ_IDX] != rd_ptr[LSQ_IDX]);
    assign empty = (wr_ptr == rd_ptr);

    assign disp_ready = ~full;
    assign enqueue    = disp_valid && ~full;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dequeue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
        end else begin
            if (enqueue) begin
                occupied[wr_idx] <= 1'b1;
            end
            if (dequeue) begin
                occupied[rd_idx] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Slot update
    ////////////////////////////////////////

    // AGU results may come back in any order
    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            agu_hit[i] = agu_res_valid && occupied[i]
                         && (entries[i].rob_id == agu_res.rob_id);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (enqueue && (LSQ_IDX'(i) == wr_idx)) begin
                entries[i].rob_id <= disp_uop.rob_id;
                entries[i].rd_phy <= disp_uop.rd_phy;
                entries[i].op     <= disp_uop.op;
                entries[i].ready  <= 1'b0;
            end else if (agu_hit[i]) begin
                entries[i].ready <= 1'b1;
                entries[i].addr  <= agu_res.addr;
                entries[i].mask  <= agu_res.mask;
                entries[i].wdata <= agu_res.wdata;
            end
        end
    end

    ////////////////////////////////////////
    // Issue to memory
    ////////////////////////////////////////

    assign head       = entries[rd_idx];
    assign head_store = head.op[3];

    // Stores are held until they reach the ROB head
    assign issue   = ~empty && head.ready && (~head_store || (rob_head == head.rob_id));
    assign dequeue = issue && dmem_resp;

    always_comb begin
        dmem_req.addr  = {head.addr[XLEN-1:2], 2'b00};
        dmem_req.wdata = head.wdata;
        dmem_req.rmask = (issue && ~head_store && ~dmem_resp) ? head.mask : 4'b0000;
        dmem_req.wmask = (issue && head_store && ~dmem_resp) ? head.mask : 4'b0000;
    end

    assign head_op     = head.op;
    assign head_offset = head.addr[1:0];

    ////////////////////////////////////////
    // Result broadcast
    ////////////////////////////////////////

    assign cdb_valid  = dequeue;
    assign cdb.rob_id = head.rob_id;
    assign cdb.rd_phy = head.rd_phy;
    assign cdb.value  = head_store ? '0 : load_value;

endmodule

`default_nettype wire

/* design/lsu_agu.sv */
`default_nettype none

module lsu_agu (
    input  logic             clk,
    input  logic             rst,
    input  logic             agu_valid,
    input  lsu_pkg::agu_req_t agu_req,
    input  lsu_pkg::lsu_op_e agu_op,
    output logic             agu_res_valid,
    output lsu_pkg::agu_res_t agu_res
);

    import lsu_pkg::*;

    logic [XLEN-1:0] addr;
    logic [3:0]      mask;
    logic [XLEN-1:0] wdata;

    assign addr = agu_req.rs1 + {{(XLEN-12){agu_req.imm[11]}}, agu_req.imm};

    // Byte lanes touched by the access
    always_comb begin
        case (agu_op[1:0])
            2'b00:   mask = 4'b0001 << addr[1:0];
            2'b01:   mask = 4'b0011 << {addr[1], 1'b0};
            default: mask = 4'b1111;
        endcase
    end

    // Store data moved into its lanes
    always_comb begin
        wdata = '0;
        if (agu_op[3]) begin
            case (agu_op[1:0])
                2'b00:   wdata = {24'b0, agu_req.rs2[7:0]} << {addr[1:0], 3'b000};
                2'b01:   wdata = {16'b0, agu_req.rs2[15:0]} << {addr[1], 4'b0000};
                default: wdata = agu_req.rs2;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            agu_res_valid <= 1'b0;
        end else begin
            agu_res_valid <= agu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (agu_valid) begin
            agu_res.rob_id <= agu_req.rob_id;
            agu_res.addr   <= addr;
            agu_res.mask   <= mask;
            agu_res.wdata  <= wdata;
        end
    end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int XLEN    = 32;
    localparam int ROB_IDX = 5;
    localparam int PHY_IDX = 6;

    ////////////////////////////////////////
    // Memory opcodes
    ////////////////////////////////////////

    // Bit 3 marks a store, bits 1:0 give the access size
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } lsu_op_e;

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////

    // From dispatch
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        lsu_op_e            op;
    } lsu_uop_t;

    // Register operands for address generation
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [XLEN-1:0]    rs1;
        logic [XLEN-1:0]    rs2;
        logic [11:0]        imm;
    } agu_req_t;

    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [XLEN-1:0]    addr;
        logic [3:0]         mask;
        logic [XLEN-1:0]    wdata;
    } agu_res_t;

    // One queue slot
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        lsu_op_e            op;
        logic               ready;
        logic [XLEN-1:0]    addr;
        logic [3:0]         mask;
        logic [XLEN-1:0]    wdata;
    } lsq_entry_t;

    // Word aligned, active while either mask is nonzero
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [3:0]      rmask;
        logic [3:0]      wmask;
        logic [XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        logic [XLEN-1:0]    value;
    } cdb_t;

endpackage

`default_nettype wire
